// ==== uart_cfg_pkg.sv ====
// serial side definitions for the terminal port
// clk_freq must be a whole multiple of baud and of baud*oversampling
// the 25 MHz / 115200 / 16 defaults do not divide exactly
// and run the receiver sample rate about 4 percent fast
package uart_cfg_pkg;

  // one character as it travels on the cpu bus and on the wire
  typedef logic [7:0] byte_t;

  // board clock the defaults were chosen for
  localparam int def_clk_freq = 25_000_000;

  // terminal line rate
  localparam int def_baud = 115_200;

  // receiver samples per bit
  // keep it even and at least 2 so a middle sample exists
  localparam int def_oversampling = 16;

endpackage

// ==== pia_reg_pkg.sv ====
// cpu side register map of the terminal port
// four byte wide registers behind a 2 bit address
// bit 7 carries the status flags in the apple 1 keyboard and display style
package pia_reg_pkg;

  // register offset within the port window
  typedef logic [1:0] reg_addr_t;

  // register select
  // reg_rx reads the keyboard byte with bit 7 high
  // reg_rxcr has keyboard status in bit 7
  // reg_tx takes display writes and shows busy in bit 7 on read
  // reg_txcr has no function and reads zero
  typedef enum reg_addr_t {
    reg_rx   = 2'd0,
    reg_rxcr = 2'd1,
    reg_tx   = 2'd2,
    reg_txcr = 2'd3
  } pia_reg_e;

endpackage

// ==== baud_tick.sv ====
// free running clock divider giving a one cycle tick every div clocks
// div must be 1 or more and is taken as an exact integer
// the count restarts on rst so tick phase is fixed from reset
`timescale 1ns/1ps

module baud_tick #(
  parameter int div = 16
) (
  input  logic clk,
  input  logic rst,
  output logic tick
);

  // at least one counter bit even when div is 1
  localparam int cw = (div > 1) ? $clog2(div) : 1;

  logic [cw-1:0] cnt;
  logic          wrap;

  // last count of the period
  assign wrap = (cnt == cw'(div - 1));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt  <= '0;
      tick <= 1'b0;
    end else begin
      // tick is registered so it lines up with the cycle after the wrap
      tick <= wrap;
      if (wrap) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

endmodule

// ==== uart_tx.sv ====
// 8N1 transmitter stepped by an external bit tick
// tx_start is ignored unless the transmitter is idle
// the start bit waits for the next bit_tick so latency varies up to one bit
`timescale 1ns/1ps

module uart_tx (
  input  logic                clk,
  input  logic                rst,
  input  logic                bit_tick,
  input  logic                tx_start,
  input  uart_cfg_pkg::byte_t tx_data,
  output logic                uart_tx,
  output logic                tx_busy
);

  import uart_cfg_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } tx_state_e;

  tx_state_e  state;
  logic [2:0] bit_cnt;
  byte_t      shift;

  // busy for the whole frame including the wait for the first tick
  assign tx_busy = (state != st_idle);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state   <= st_idle;
      bit_cnt <= '0;
      uart_tx <= 1'b1;
    end else begin
      case (state)
        st_idle: begin
          uart_tx <= 1'b1;
          if (tx_start) begin
            state <= st_start;
          end
        end
        st_start: begin
          // start bit goes out on a tick boundary
          if (bit_tick) begin
            uart_tx <= 1'b0;
            bit_cnt <= '0;
            state   <= st_data;
          end
        end
        st_data: begin
          if (bit_tick) begin
            // lsb first
            uart_tx <= shift[0];
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= st_stop;
            end
          end
        end
        st_stop: begin
          // bit_cnt wrapped to 0 on entry
          // first tick drives the stop bit and the second ends it
          if (bit_tick) begin
            uart_tx <= 1'b1;
            if (bit_cnt == 3'd0) begin
              bit_cnt <= 3'd1;
            end else begin
              state <= st_idle;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // data shifter
  always_ff @(posedge clk) begin
    if (state == st_idle && tx_start) begin
      shift <= tx_data;
    end else if (state == st_data && bit_tick) begin
      shift <= {1'b0, shift[7:1]};
    end
  end

endmodule

// ==== uart_rx.sv ====
// oversampling 8N1 receiver fed by a sample tick at baud*oversampling
// oversampling must be even and at least 2
// frames with a low stop bit are dropped without any error output
// rx_idle needs 10 bit times of high line before it rises
`timescale 1ns/1ps

module uart_rx #(
  parameter int oversampling = 16
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                sample_tick,
  input  logic                uart_rx,
  output uart_cfg_pkg::byte_t rx_data,
  output logic                rx_ready,
  output logic                rx_idle
);

  import uart_cfg_pkg::*;

  localparam int cw      = $clog2(oversampling);
  localparam int gap_len = 10 * oversampling;
  localparam int gw      = $clog2(gap_len);

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } rx_state_e;

  rx_state_e     state;
  logic [2:0]    sync;
  logic          line;
  logic          fall;
  logic [cw-1:0] os_cnt;
  logic [2:0]    bit_cnt;
  logic          mid_tick;
  logic          bit_end;
  byte_t         shift;
  logic [gw-1:0] gap_cnt;

  // sync[1] is the clean line, sync[2] is one clock older for edge detect
  assign line = sync[1];
  assign fall = sync[2] & ~sync[1];

  // middle of the start bit, then one full bit per sample after that
  assign mid_tick = sample_tick && (os_cnt == cw'(oversampling / 2 - 1));
  assign bit_end  = sample_tick && (os_cnt == cw'(oversampling - 1));

  // two flop synchronizer plus edge flop, idles high
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sync <= 3'b111;
    end else begin
      sync <= {sync[1:0], uart_rx};
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= st_idle;
      os_cnt   <= '0;
      bit_cnt  <= '0;
      rx_ready <= 1'b0;
    end else begin
      rx_ready <= 1'b0;
      case (state)
        st_idle: begin
          if (fall) begin
            os_cnt <= '0;
            state  <= st_start;
          end
        end
        st_start: begin
          if (mid_tick) begin
            os_cnt  <= '0;
            bit_cnt <= '0;
            // a high line here was a glitch, not a start bit
            state   <= line ? st_idle : st_data;
          end else if (sample_tick) begin
            os_cnt <= os_cnt + 1'b1;
          end
        end
        st_data: begin
          if (bit_end) begin
            os_cnt  <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= st_stop;
            end
          end else if (sample_tick) begin
            os_cnt <= os_cnt + 1'b1;
          end
        end
        st_stop: begin
          if (bit_end) begin
            os_cnt   <= '0;
            rx_ready <= line;
            state    <= st_idle;
          end else if (sample_tick) begin
            os_cnt <= os_cnt + 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // data path, bits arrive lsb first
  always_ff @(posedge clk) begin
    if (state == st_data && bit_end) begin
      shift <= {line, shift[7:1]};
    end
    if (state == st_stop && bit_end && line) begin
      rx_data <= shift;
    end
  end

  // line idle detect, any low level restarts the gap count
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      gap_cnt <= '0;
      rx_idle <= 1'b1;
    end else if (!line) begin
      gap_cnt <= '0;
      rx_idle <= 1'b0;
    end else if (sample_tick && !rx_idle) begin
      if (gap_cnt == gw'(gap_len - 1)) begin
        rx_idle <= 1'b1;
      end else begin
        gap_cnt <= gap_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== uart_regs.sv ====
// cpu register block of the terminal port
// single byte receive holding register, new bytes are dropped while it is full
// the first write to reg_tx after reset is swallowed as the monitor pia setup
// writes while the transmitter is busy are lost
`timescale 1ns/1ps

module uart_regs (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   enable,
  input  pia_reg_pkg::reg_addr_t address,
  input  logic                   w_en,
  input  uart_cfg_pkg::byte_t    din,
  output uart_cfg_pkg::byte_t    dout,
  output logic                   tx_start,
  output uart_cfg_pkg::byte_t    tx_data,
  input  logic                   tx_busy,
  input  uart_cfg_pkg::byte_t    rx_data,
  input  logic                   rx_ready,
  input  logic                   rx_idle,
  output logic                   uart_cts
);

  import uart_cfg_pkg::*;
  import pia_reg_pkg::*;

  pia_reg_e reg_sel;
  byte_t    rx_byte;
  logic     rx_status;
  logic     rx_ack;
  logic     tx_init;
  logic     tx_go;
  logic     ack_go;

  assign reg_sel = pia_reg_e'(address);

  // send only after the setup write, when idle, and not right after a start
  assign tx_go = (reg_sel == reg_tx) && w_en && tx_init && !tx_busy && !tx_start;

  // keyboard read with enable acknowledges a waiting byte once
  assign ack_go = (reg_sel == reg_rx) && !w_en && enable && rx_status && !rx_ack;

  // terminal may not send while a frame arrives or a byte is unread
  assign uart_cts = !rx_idle || rx_status;

  // receive holding register
  // an ack on the same edge as rx_ready wins, so that byte is lost
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rx_status <= 1'b0;
      rx_byte   <= '0;
    end else begin
      if (rx_ready && !rx_status) begin
        rx_status <= 1'b1;
        rx_byte   <= rx_data;
      end
      if (rx_ack) begin
        rx_status <= 1'b0;
      end
    end
  end

  // bus side strobes and registered read data
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      dout     <= '0;
      tx_start <= 1'b0;
      rx_ack   <= 1'b0;
      tx_init  <= 1'b0;
    end else begin
      tx_start <= tx_go;
      rx_ack   <= ack_go;
      if (reg_sel == reg_tx && w_en && enable && !tx_init) begin
        tx_init <= 1'b1;
      end
      case (reg_sel)
        // keyboard bit 7 always reads high
        reg_rx:   dout <= {1'b1, rx_byte[6:0]};
        reg_rxcr: dout <= {rx_status, 7'b0};
        reg_tx:   dout <= {tx_busy, 7'b0};
        reg_txcr: dout <= '0;
        default:  dout <= '0;
      endcase
    end
  end

  // display byte, terminal is 7 bit so bit 7 goes out low
  always_ff @(posedge clk) begin
    if (tx_go) begin
      tx_data <= {1'b0, din[6:0]};
    end
  end

endmodule

// ==== pia_uart.sv ====
// apple 1 style keyboard and display port over an 8N1 serial line
// clk_freq must divide exactly by baud and by baud*oversampling
// no parity, no fifo, no interrupt and no transmit flow control
`timescale 1ns/1ps

module pia_uart #(
  parameter int clk_freq     = uart_cfg_pkg::def_clk_freq,
  parameter int baud         = uart_cfg_pkg::def_baud,
  parameter int oversampling = uart_cfg_pkg::def_oversampling
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   enable,
  input  pia_reg_pkg::reg_addr_t address,
  input  logic                   w_en,
  input  uart_cfg_pkg::byte_t    din,
  output uart_cfg_pkg::byte_t    dout,
  input  logic                   uart_rx,
  output logic                   uart_tx,
  output logic                   uart_cts
);

  import uart_cfg_pkg::*;

  // clocks per bit and per receiver sample
  localparam int bit_div    = clk_freq / baud;
  localparam int sample_div = clk_freq / (baud * oversampling);

  logic  bit_tick;
  logic  sample_tick;
  logic  tx_start;
  logic  tx_busy;
  logic  rx_ready;
  logic  rx_idle;
  byte_t tx_data;
  byte_t rx_data;

  uart_regs u_regs (
    .clk      (clk),
    .rst      (rst),
    .enable   (enable),
    .address  (address),
    .w_en     (w_en),
    .din      (din),
    .dout     (dout),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .tx_busy  (tx_busy),
    .rx_data  (rx_data),
    .rx_ready (rx_ready),
    .rx_idle  (rx_idle),
    .uart_cts (uart_cts)
  );

  baud_tick #(.div(bit_div)) u_bit_tick (
    .clk  (clk),
    .rst  (rst),
    .tick (bit_tick)
  );

  baud_tick #(.div(sample_div)) u_sample_tick (
    .clk  (clk),
    .rst  (rst),
    .tick (sample_tick)
  );

  uart_tx u_tx (
    .clk      (clk),
    .rst      (rst),
    .bit_tick (bit_tick),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .uart_tx  (uart_tx),
    .tx_busy  (tx_busy)
  );

  uart_rx #(.oversampling(oversampling)) u_rx (
    .clk         (clk),
    .rst         (rst),
    .sample_tick (sample_tick),
    .uart_rx     (uart_rx),
    .rx_data     (rx_data),
    .rx_ready    (rx_ready),
    .rx_idle     (rx_idle)
  );

endmodule

// ==== pia_uart_props.sv ====
// concurrent checks on the register block strobes
// bound into every uart_regs instance, idle during reset
`timescale 1ns/1ps

module pia_uart_props (
  input logic clk,
  input logic rst,
  input logic tx_start,
  input logic tx_busy,
  input logic rx_ack,
  input logic rx_status,
  input logic rx_ready
);

  // a start request only goes to an idle transmitter
  a_start_when_idle: assert property (
    @(posedge clk) disable iff (rst) $rose(tx_start) |-> !tx_busy
  ) else $error("tx_start rose while tx_busy was high");

  // keyboard ack is a single cycle pulse
  a_ack_one_cycle: assert property (
    @(posedge clk) disable iff (rst) rx_ack |=> !rx_ack
  ) else $error("rx_ack held for more than one cycle");

  // status only sets from a received byte
  a_status_from_ready: assert property (
    @(posedge clk) disable iff (rst) $rose(rx_status) |-> $past(rx_ready)
  ) else $error("rx_status set without rx_ready");

endmodule

bind uart_regs pia_uart_props u_props (
  .clk       (clk),
  .rst       (rst),
  .tx_start  (tx_start),
  .tx_busy   (tx_busy),
  .rx_ack    (rx_ack),
  .rx_status (rx_status),
  .rx_ready  (rx_ready)
);

// ==== tb_pia_uart.sv ====
// directed testbench for the terminal port at 16 clocks per bit
// the serial line models sample at negedges, bus inputs change on posedges
// stops with a failure after a fixed cycle limit
`timescale 1ns/1ps

module tb_pia_uart;

  import uart_cfg_pkg::*;
  import pia_reg_pkg::*;

  localparam int clk_freq     = 1_000_000;
  localparam int baud         = 62_500;
  localparam int oversampling = 4;
  localparam int bit_clks     = clk_freq / baud;
  localparam int frame_clks   = 10 * bit_clks;
  // tests need roughly 6000 cycles
  localparam int cycle_limit  = 20000;

  logic      clk;
  logic      rst;
  logic      enable;
  logic      w_en;
  reg_addr_t address;
  byte_t     din;
  byte_t     dout;
  logic      uart_rx;
  logic      uart_tx;
  logic      uart_cts;

  int seed = 32'h7a3a2bd3;
  int errors;
  int checks;
  int tests;
  int cycles;

  pia_uart #(
    .clk_freq     (clk_freq),
    .baud         (baud),
    .oversampling (oversampling)
  ) dut (
    .clk      (clk),
    .rst      (rst),
    .enable   (enable),
    .address  (address),
    .w_en     (w_en),
    .din      (din),
    .dout     (dout),
    .uart_rx  (uart_rx),
    .uart_tx  (uart_tx),
    .uart_cts (uart_cts)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // hard stop in case a wait never ends
  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("run stopped, no result after %0d cycles", cycle_limit);
    $display("=== FAIL ===");
    $finish;
  end

  task automatic compare_byte(string what, byte_t got, byte_t exp);
    checks++;
    assert (got === exp) else begin
      $display("Fail %0t: %s gave %02h, expected %02h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(string name, int err_before);
    tests++;
    $display("test %-14s %s", name, (errors == err_before) ? "ok" : "failed");
  endtask

  // single cycle write strobe
  task automatic bus_write(reg_addr_t a, byte_t d);
    @(posedge clk);
    address <= a;
    din     <= d;
    w_en    <= 1'b1;
    enable  <= 1'b1;
    @(posedge clk);
    w_en    <= 1'b0;
    enable  <= 1'b0;
  endtask

  // dout is registered, so it is taken one cycle after the address
  task automatic read_reg(reg_addr_t a, logic en, output byte_t value);
    @(posedge clk);
    address <= a;
    w_en    <= 1'b0;
    enable  <= en;
    @(posedge clk);
    enable  <= 1'b0;
    @(negedge clk);
    value = dout;
  endtask

  task automatic read_check(reg_addr_t a, logic en, byte_t exp, string what);
    byte_t v;
    read_reg(a, en, v);
    compare_byte(what, v, exp);
  endtask

  // serial frame into the receiver, start bit in bit 0 of the shift word
  task automatic send_rx_frame(byte_t d);
    logic [9:0] frame;
    int         i;
    frame = {1'b1, d, 1'b0};
    for (i = 0; i < 10; i++) begin
      @(posedge clk);
      uart_rx <= frame[i];
      repeat (bit_clks - 1) @(posedge clk);
    end
  endtask

  // line monitor, finds the start edge then samples at bit centers
  task automatic capture_tx_frame(output byte_t data, output logic seen);
    int n;
    int i;
    n    = 0;
    data = '0;
    seen = 1'b0;
    while (uart_tx !== 1'b0 && n < 2 * frame_clks) begin
      @(negedge clk);
      n++;
    end
    checks++;
    assert (uart_tx === 1'b0) else begin
      $display("no start bit on uart_tx within %0d cycles", 2 * frame_clks);
      errors++;
    end
    if (uart_tx === 1'b0) begin
      seen = 1'b1;
      repeat (bit_clks / 2) @(negedge clk);
      compare_byte("tx start bit", byte_t'(uart_tx), 8'h00);
      for (i = 0; i < 8; i++) begin
        repeat (bit_clks) @(negedge clk);
        data[i] = uart_tx;
      end
      repeat (bit_clks) @(negedge clk);
      compare_byte("tx stop bit", byte_t'(uart_tx), 8'h01);
    end
  endtask

  task automatic expect_line_high(int n_cycles, string what);
    int   n;
    logic low_seen;
    low_seen = 1'b0;
    for (n = 0; n < n_cycles && !low_seen; n++) begin
      @(negedge clk);
      if (uart_tx !== 1'b1) low_seen = 1'b1;
    end
    checks++;
    assert (!low_seen) else begin
      $display("Fail %0t: uart_tx went low during %s", $time, what);
      errors++;
    end
  endtask

  task automatic wait_cts(logic level, int limit, string what);
    int n;
    n = 0;
    while (uart_cts !== level && n < limit) begin
      @(negedge clk);
      n++;
    end
    checks++;
    assert (uart_cts === level) else begin
      $display("%s: uart_cts did not go to %0b within %0d cycles", what, level, limit);
      errors++;
    end
  endtask

  task automatic test_reset_state();
    int err0;
    err0 = errors;
    @(negedge clk);
    compare_byte("uart_tx after reset", byte_t'(uart_tx), 8'h01);
    compare_byte("uart_cts after reset", byte_t'(uart_cts), 8'h00);
    read_check(reg_rxcr, 1'b0, 8'h00, "reg_rxcr after reset");
    read_check(reg_tx, 1'b0, 8'h00, "reg_tx after reset");
    read_check(reg_txcr, 1'b0, 8'h00, "reg_txcr after reset");
    report_test("reset", err0);
  endtask

  // the monitor program's setup write must not reach the line
  task automatic test_first_write();
    int err0;
    err0 = errors;
    bus_write(reg_tx, byte_t'($random(seed)));
    expect_line_high(2 * frame_clks, "swallowed first write");
    report_test("first_write", err0);
  endtask

  task automatic test_transmit();
    int    err0;
    int    n;
    byte_t d;
    byte_t got;
    byte_t v;
    logic  seen;
    err0 = errors;
    // bit 7 set so the 7 bit mask shows on the line
    d    = byte_t'($random(seed)) | 8'h80;
    bus_write(reg_tx, d);
    fork
      capture_tx_frame(got, seen);
      begin
        // mid frame, busy shows and a second write is dropped
        repeat (3 * bit_clks) @(posedge clk);
        read_check(reg_tx, 1'b0, 8'h80, "reg_tx busy during frame");
        bus_write(reg_tx, ~d);
      end
    join
    if (seen) begin
      compare_byte("tx frame data", got, {1'b0, d[6:0]});
    end
    // busy ends half a bit after the stop bit center
    n = 0;
    v = 8'h80;
    while (v[7] && n < 4 * bit_clks) begin
      read_reg(reg_tx, 1'b0, v);
      n++;
    end
    compare_byte("reg_tx after frame", v, 8'h00);
    expect_line_high(2 * frame_clks, "write while busy");
    report_test("transmit", err0);
  endtask

  task automatic test_receive();
    int    err0;
    byte_t d;
    err0 = errors;
    // bit 7 clear on the wire so the forced high bit shows in the read
    d    = byte_t'($random(seed)) & 8'h7f;
    fork
      send_rx_frame(d);
      wait_cts(1'b1, frame_clks, "receive frame");
    join
    read_check(reg_rxcr, 1'b1, 8'h80, "reg_rxcr after receive");
    read_check(reg_rx, 1'b1, {1'b1, d[6:0]}, "reg_rx data");
    read_check(reg_rxcr, 1'b1, 8'h00, "reg_rxcr after ack");
    wait_cts(1'b0, 3 * frame_clks, "line idle after receive");
    report_test("receive", err0);
  endtask

  task automatic test_overrun();
    int    err0;
    byte_t d1;
    byte_t d2;
    err0 = errors;
    d1   = byte_t'($random(seed));
    d2   = byte_t'($random(seed));
    // second byte must differ in the visible bits
    if (d2[6:0] == d1[6:0]) d2 = d1 ^ 8'h2a;
    send_rx_frame(d1);
    send_rx_frame(d2);
    read_check(reg_rx, 1'b1, {1'b1, d1[6:0]}, "reg_rx keeps first byte");
    read_check(reg_rxcr, 1'b1, 8'h00, "reg_rxcr after overrun ack");
    wait_cts(1'b0, 3 * frame_clks, "line idle after overrun");
    report_test("overrun", err0);
  endtask

  task automatic test_read_no_enable();
    int    err0;
    byte_t d;
    err0 = errors;
    d    = byte_t'($random(seed));
    send_rx_frame(d);
    read_check(reg_rx, 1'b0, {1'b1, d[6:0]}, "reg_rx without enable");
    read_check(reg_rxcr, 1'b0, 8'h80, "reg_rxcr kept without enable");
    read_check(reg_txcr, 1'b1, 8'h00, "reg_txcr with enable");
    read_check(reg_txcr, 1'b0, 8'h00, "reg_txcr without enable");
    read_check(reg_rx, 1'b1, {1'b1, d[6:0]}, "reg_rx with enable");
    read_check(reg_rxcr, 1'b1, 8'h00, "reg_rxcr after ack");
    wait_cts(1'b0, 3 * frame_clks, "line idle after read");
    report_test("no_enable", err0);
  endtask

  initial begin
    rst     = 1'b1;
    enable  = 1'b0;
    w_en    = 1'b0;
    address = reg_rx;
    din     = '0;
    uart_rx = 1'b1;
    errors  = 0;
    checks  = 0;
    tests   = 0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    test_reset_state();
    test_first_write();
    test_transmit();
    test_receive();
    test_overrun();
    test_read_no_enable();
    $display("tests %0d  checks %0d  errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== pia_uart.f ====
uart_cfg_pkg.sv
pia_reg_pkg.sv
baud_tick.sv
uart_tx.sv
uart_rx.sv
uart_regs.sv
pia_uart.sv
pia_uart_props.sv
tb_pia_uart.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_pia_uart
FILELIST := pia_uart.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "=== FAIL ===" >> $(LOG)
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
